// File: Makefile
TOP       ?= alu_core_tb
SEED      ?= 77
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= verilog.f
VERILATOR ?= verilator

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -j 0
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) 2>&1 | tee $(LOG)
	@grep -q "^No errors$$" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hw/alu_core.sv
`timescale 1ns/1ps

module alu_core
import alu_core_pkg::*;
(
    input   logic       clk,
    input   logic       rst_n_i,

    input   logic       instr_valid_i,
    input   instr_t     instr_i,

    output  logic       cdb_valid_o,
    output  arch_reg_t  cdb_rd_o,
    output  word_t      cdb_data_o,
    output  logic       illegal_o
);
    arch_reg_t  rs1_addr;
    arch_reg_t  rs2_addr;
    word_t      rs1_data;
    word_t      rs2_data;

    logic       ex_valid;
    alu_op_t    ex_op;
    arch_reg_t  ex_rd;
    arch_reg_t  ex_rs1;
    arch_reg_t  ex_rs2;
    logic       ex_use_imm;
    word_t      ex_imm;
    word_t      ex_rs1_data;
    word_t      ex_rs2_data;

    logic       cdb_valid;
    arch_reg_t  cdb_rd;
    word_t      cdb_data;

    alu_decode i_decode (
        .clk,
        .rst_n_i,
        .instr_valid_i,
        .instr_i,
        .rs1_addr_o     (rs1_addr),
        .rs2_addr_o     (rs2_addr),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .ex_valid_o     (ex_valid),
        .ex_op_o        (ex_op),
        .ex_rd_o        (ex_rd),
        .ex_rs1_o       (ex_rs1),
        .ex_rs2_o       (ex_rs2),
        .ex_use_imm_o   (ex_use_imm),
        .ex_imm_o       (ex_imm),
        .ex_rs1_data_o  (ex_rs1_data),
        .ex_rs2_data_o  (ex_rs2_data),
        .illegal_o
    );

    alu_execute i_execute (
        .clk,
        .rst_n_i,
        .ex_valid_i     (ex_valid),
        .ex_op_i        (ex_op),
        .ex_rd_i        (ex_rd),
        .ex_rs1_i       (ex_rs1),
        .ex_rs2_i       (ex_rs2),
        .ex_use_imm_i   (ex_use_imm),
        .ex_imm_i       (ex_imm),
        .ex_rs1_data_i  (ex_rs1_data),
        .ex_rs2_data_i  (ex_rs2_data),
        .cdb_valid_o    (cdb_valid),
        .cdb_rd_o       (cdb_rd),
        .cdb_data_o     (cdb_data)
    );

    // broadcast also writes back
    alu_result i_result (
        .clk,
        .rst_n_i,
        .cdb_valid_i    (cdb_valid),
        .cdb_rd_i       (cdb_rd),
        .cdb_data_i     (cdb_data),
        .rs1_addr_i     (rs1_addr),
        .rs2_addr_i     (rs2_addr),
        .rs1_data_o     (rs1_data),
        .rs2_data_o     (rs2_data)
    );

    assign cdb_valid_o = cdb_valid;
    assign cdb_rd_o    = cdb_rd;
    assign cdb_data_o  = cdb_data;

endmodule : alu_core

// File: hw/alu_core_pkg.sv
package alu_core_pkg;

    localparam int XLEN          = 32;
    localparam int NUM_ARCH_REGS = 32;
    localparam int ARCH_REG_BITS = $clog2(NUM_ARCH_REGS);

    typedef logic [XLEN-1:0]          word_t;
    typedef logic [31:0]              instr_t;
    typedef logic [ARCH_REG_BITS-1:0] arch_reg_t;

    // rv32i major opcodes
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;

    localparam logic [2:0] FUNCT3_ADD  = 3'b000;
    localparam logic [2:0] FUNCT3_SLL  = 3'b001;
    localparam logic [2:0] FUNCT3_SLT  = 3'b010;
    localparam logic [2:0] FUNCT3_SLTU = 3'b011;
    localparam logic [2:0] FUNCT3_XOR  = 3'b100;
    localparam logic [2:0] FUNCT3_SR   = 3'b101;
    localparam logic [2:0] FUNCT3_OR   = 3'b110;
    localparam logic [2:0] FUNCT3_AND  = 3'b111;

    // alt selects sub and sra
    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_LUI
    } alu_op_t;

endpackage : alu_core_pkg

// File: hw/alu_decode.sv
`timescale 1ns/1ps

module alu_decode
import alu_core_pkg::*;
(
    input   logic       clk,
    input   logic       rst_n_i,

    input   logic       instr_valid_i,
    input   instr_t     instr_i,

    output  arch_reg_t  rs1_addr_o,
    output  arch_reg_t  rs2_addr_o,
    input   word_t      rs1_data_i,
    input   word_t      rs2_data_i,

    output  logic       ex_valid_o,
    output  alu_op_t    ex_op_o,
    output  arch_reg_t  ex_rd_o,
    output  arch_reg_t  ex_rs1_o,
    output  arch_reg_t  ex_rs2_o,
    output  logic       ex_use_imm_o,
    output  word_t      ex_imm_o,
    output  word_t      ex_rs1_data_o,
    output  word_t      ex_rs2_data_o,
    output  logic       illegal_o
);
    logic   [6:0]   opcode;
    logic   [2:0]   funct3;
    logic   [6:0]   funct7;
    word_t          imm_i;
    word_t          imm_u;

    alu_op_t        dec_op;
    logic           dec_use_imm;
    word_t          dec_imm;
    logic           dec_legal;

    // funct3 group to operation, alt picks sub/sra
    function automatic alu_op_t base_op(input logic [2:0] f3, input logic alt);
        case (f3)
            FUNCT3_ADD:  return alt ? ALU_SUB : ALU_ADD;
            FUNCT3_SLL:  return ALU_SLL;
            FUNCT3_SLT:  return ALU_SLT;
            FUNCT3_SLTU: return ALU_SLTU;
            FUNCT3_XOR:  return ALU_XOR;
            FUNCT3_SR:   return alt ? ALU_SRA : ALU_SRL;
            FUNCT3_OR:   return ALU_OR;
            default:     return ALU_AND;
        endcase
    endfunction

    assign opcode     = instr_i[6:0];
    assign funct3     = instr_i[14:12];
    assign funct7     = instr_i[31:25];
    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_u = {instr_i[31:12], 12'b0};

    always_comb begin
        dec_op      = ALU_ADD;
        dec_use_imm = 1'b0;
        dec_imm     = imm_i;
        dec_legal   = 1'b0;
        case (opcode)
            OPCODE_OP: begin
                dec_legal = (funct7 == FUNCT7_BASE) ||
                            ((funct7 == FUNCT7_ALT) &&
                             ((funct3 == FUNCT3_ADD) || (funct3 == FUNCT3_SR)));
                dec_op    = base_op(funct3, funct7 == FUNCT7_ALT);
            end
            OPCODE_OP_IMM: begin
                dec_use_imm = 1'b1;
                // only the shift encodings constrain imm[11:5]
                if (funct3 == FUNCT3_SLL) begin
                    dec_legal = (funct7 == FUNCT7_BASE);
                end else if (funct3 == FUNCT3_SR) begin
                    dec_legal = (funct7 == FUNCT7_BASE) || (funct7 == FUNCT7_ALT);
                end else begin
                    dec_legal = 1'b1;
                end
                dec_op = base_op(funct3, (funct3 == FUNCT3_SR) && (funct7 == FUNCT7_ALT));
            end
            OPCODE_LUI: begin
                dec_op      = ALU_LUI;
                dec_use_imm = 1'b1;
                dec_imm     = imm_u;
                dec_legal   = 1'b1;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_valid_o <= 1'b0;
            illegal_o  <= 1'b0;
        end else begin
            ex_valid_o <= instr_valid_i && dec_legal;
            illegal_o  <= instr_valid_i && !dec_legal;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid_i) begin
            ex_op_o       <= dec_op;
            ex_rd_o       <= instr_i[11:7];
            ex_rs1_o      <= rs1_addr_o;
            ex_rs2_o      <= rs2_addr_o;
            ex_use_imm_o  <= dec_use_imm;
            ex_imm_o      <= dec_imm;
            ex_rs1_data_o <= rs1_data_i;
            ex_rs2_data_o <= rs2_data_i;
        end
    end

    // each instruction is either issued or rejected, never both
    assert property (@(posedge clk) disable iff (!rst_n_i) !(ex_valid_o && illegal_o))
        else $error("issue and illegal pulse in the same cycle");

endmodule : alu_decode

// File: hw/alu_execute.sv
`timescale 1ns/1ps

module alu_execute
import alu_core_pkg::*;
(
    input   logic       clk,
    input   logic       rst_n_i,

    input   logic       ex_valid_i,
    input   alu_op_t    ex_op_i,
    input   arch_reg_t  ex_rd_i,
    input   arch_reg_t  ex_rs1_i,
    input   arch_reg_t  ex_rs2_i,
    input   logic       ex_use_imm_i,
    input   word_t      ex_imm_i,
    input   word_t      ex_rs1_data_i,
    input   word_t      ex_rs2_data_i,

    output  logic       cdb_valid_o,
    output  arch_reg_t  cdb_rd_o,
    output  word_t      cdb_data_o
);
    word_t          op_a;
    word_t          op_b;
    word_t          rs2_val;
    word_t          result;
    logic   [4:0]   shamt;

    // previous instruction's result still on the bus
    function automatic word_t forward(input arch_reg_t rs, input word_t read_val);
        if (cdb_valid_o && (cdb_rd_o != '0) && (cdb_rd_o == rs)) begin
            return cdb_data_o;
        end
        return read_val;
    endfunction

    always_comb begin
        op_a    = forward(ex_rs1_i, ex_rs1_data_i);
        rs2_val = forward(ex_rs2_i, ex_rs2_data_i);
        op_b    = ex_use_imm_i ? ex_imm_i : rs2_val;
    end

    assign shamt = op_b[4:0];

    always_comb begin
        case (ex_op_i)
            ALU_ADD:  result = op_a + op_b;
            ALU_SUB:  result = op_a - op_b;
            ALU_SLL:  result = op_a << shamt;
            ALU_SRL:  result = op_a >> shamt;
            ALU_SRA:  result = word_t'($signed(op_a) >>> shamt);
            ALU_SLT:  result = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU: result = word_t'(op_a < op_b);
            ALU_XOR:  result = op_a ^ op_b;
            ALU_OR:   result = op_a | op_b;
            ALU_AND:  result = op_a & op_b;
            ALU_LUI:  result = op_b;
            default:  result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cdb_valid_o <= 1'b0;
        end else begin
            cdb_valid_o <= ex_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid_i) begin
            cdb_rd_o   <= ex_rd_i;
            cdb_data_o <= result;
        end
    end

    // nothing left in flight from before reset
    assert property (@(posedge clk) $rose(rst_n_i) |=> !cdb_valid_o)
        else $error("broadcast right after reset release");

endmodule : alu_execute

// File: hw/alu_result.sv
`timescale 1ns/1ps

module alu_result
import alu_core_pkg::*;
(
    input   logic       clk,
    input   logic       rst_n_i,

    input   logic       cdb_valid_i,
    input   arch_reg_t  cdb_rd_i,
    input   word_t      cdb_data_i,

    input   arch_reg_t  rs1_addr_i,
    input   arch_reg_t  rs2_addr_i,
    output  word_t      rs1_data_o,
    output  word_t      rs2_data_o
);
    // x0 has no storage
    word_t  regs [1:NUM_ARCH_REGS-1];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < NUM_ARCH_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (cdb_valid_i && (cdb_rd_i != '0)) begin
            regs[cdb_rd_i] <= cdb_data_i;
        end
    end

    // write-through, the bus wins over the stored copy
    function automatic word_t read_port(input arch_reg_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (cdb_valid_i && (cdb_rd_i == addr)) begin
            return cdb_data_i;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_addr_i);
        rs2_data_o = read_port(rs2_addr_i);
    end

    assert property (@(posedge clk) disable iff (!rst_n_i)
        ((rs1_addr_i != '0) || (rs1_data_o == '0)) &&
        ((rs2_addr_i != '0) || (rs2_data_o == '0)))
        else $error("x0 read returned nonzero");

endmodule : alu_result

// File: verif/alu_core_tb.sv
`timescale 1ns/1ps

module alu_core_tb
import alu_core_pkg::*;
();
    localparam int RESET_CYCLES    = 8;
    localparam int RAND_COUNT      = 400;
    localparam int MAX_GAP         = 3;
    localparam int DIRECTED_CYCLES = 150;
    localparam int TIMEOUT_CYCLES  = RESET_CYCLES + 5 + DIRECTED_CYCLES
                                     + RAND_COUNT * (1 + MAX_GAP) + 50;

    logic       clk;
    logic       rst_n_i;
    logic       instr_valid_i;
    instr_t     instr_i;
    logic       cdb_valid_o;
    arch_reg_t  cdb_rd_o;
    word_t      cdb_data_o;
    logic       illegal_o;

    int         cycles = 0;
    word_t      model_regs [NUM_ARCH_REGS];
    // expected outputs in program order
    string      name_q [$];
    logic       ill_q [$];
    arch_reg_t  rd_q [$];
    word_t      data_q [$];
    int         due_q [$];

    alu_core i_dut (
        .clk,
        .rst_n_i,
        .instr_valid_i,
        .instr_i,
        .cdb_valid_o,
        .cdb_rd_o,
        .cdb_data_o,
        .illegal_o
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("FAILED %s: expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_reg(input string name, input arch_reg_t exp, input arch_reg_t act);
        if (act !== exp) begin
            $display("FAILED %s: expected rd %0d actual rd %0d", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_illegal(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s: expected illegal %b actual illegal %b", name, exp, act);
            abort_run();
        end
    endtask

    // oldest expected output against the one the DUT shows now
    task automatic compare_next(input logic got_illegal);
        if (ill_q.size() == 0) begin
            $display("ERROR: output active with no instruction outstanding");
            abort_run();
        end
        if (cycles != due_q[0]) begin
            $display("ERROR: %s result in cycle %0d, due in cycle %0d",
                     name_q[0], cycles, due_q[0]);
            abort_run();
        end
        check_illegal(name_q[0], ill_q[0], got_illegal);
        if (!ill_q[0]) begin
            check_reg(name_q[0], rd_q[0], cdb_rd_o);
            check_word(name_q[0], data_q[0], cdb_data_o);
        end
        void'(name_q.pop_front());
        void'(ill_q.pop_front());
        void'(rd_q.pop_front());
        void'(data_q.pop_front());
        void'(due_q.pop_front());
    endtask

    function automatic instr_t enc_r(input logic [6:0] f7, input arch_reg_t rs2,
                                     input arch_reg_t rs1, input logic [2:0] f3,
                                     input arch_reg_t rd);
        return {f7, rs2, rs1, f3, rd, OPCODE_OP};
    endfunction

    function automatic instr_t enc_i(input logic [11:0] imm, input arch_reg_t rs1,
                                     input logic [2:0] f3, input arch_reg_t rd);
        return {imm, rs1, f3, rd, OPCODE_OP_IMM};
    endfunction

    function automatic instr_t enc_u(input logic [19:0] imm, input arch_reg_t rd);
        return {imm, rd, OPCODE_LUI};
    endfunction

    // rv32i rules for the three kept opcodes
    function automatic bit is_legal(input instr_t ins);
        logic [6:0] f7;
        logic [2:0] f3;
        f7 = ins[31:25];
        f3 = ins[14:12];
        case (ins[6:0])
            OPCODE_LUI: return 1'b1;
            OPCODE_OP: begin
                return (f7 == FUNCT7_BASE) ||
                       ((f7 == FUNCT7_ALT) && ((f3 == FUNCT3_ADD) || (f3 == FUNCT3_SR)));
            end
            OPCODE_OP_IMM: begin
                if (f3 == FUNCT3_SLL) return f7 == FUNCT7_BASE;
                if (f3 == FUNCT3_SR) return (f7 == FUNCT7_BASE) || (f7 == FUNCT7_ALT);
                return 1'b1;
            end
            default: return 1'b0;
        endcase
    endfunction

    function automatic word_t ref_alu(input instr_t ins, input word_t a, input word_t rs2_val);
        word_t      b;
        logic [4:0] sh;
        if (ins[6:0] == OPCODE_LUI) return {ins[31:12], 12'h000};
        b  = (ins[6:0] == OPCODE_OP) ? rs2_val : {{20{ins[31]}}, ins[31:20]};
        sh = b[4:0];
        case (ins[14:12])
            FUNCT3_ADD:  return ((ins[6:0] == OPCODE_OP) && ins[30]) ? a - b : a + b;
            FUNCT3_SLL:  return a << sh;
            FUNCT3_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            FUNCT3_SLTU: return (a < b) ? 32'd1 : 32'd0;
            FUNCT3_XOR:  return a ^ b;
            FUNCT3_SR:   return ins[30] ? word_t'($signed(a) >>> sh) : a >> sh;
            FUNCT3_OR:   return a | b;
            default:     return a & b;
        endcase
    endfunction

    task automatic issue(input string name, input instr_t ins);
        arch_reg_t  rd;
        word_t      val;
        @(posedge clk);
        #1;
        instr_valid_i = 1'b1;
        instr_i       = ins;
        rd            = ins[11:7];
        name_q.push_back(name);
        if (is_legal(ins)) begin
            val = ref_alu(ins, model_regs[ins[19:15]], model_regs[ins[24:20]]);
            if (rd != '0) model_regs[rd] = val;
            ill_q.push_back(1'b0);
            rd_q.push_back(rd);
            data_q.push_back(val);
            due_q.push_back(cycles + 2);
        end else begin
            ill_q.push_back(1'b1);
            rd_q.push_back('0);
            data_q.push_back('0);
            due_q.push_back(cycles + 1);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            instr_valid_i = 1'b0;
            instr_i       = '0;
        end
    endtask

    function automatic instr_t random_instr();
        int          kind;
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [11:0] imm;
        arch_reg_t   rd;
        arch_reg_t   rs1;
        arch_reg_t   rs2;
        kind = int'($urandom_range(0, 15));
        f3   = 3'($urandom_range(0, 7));
        imm  = 12'($urandom);
        // few registers so that dependencies are frequent
        rd   = arch_reg_t'($urandom_range(0, 7));
        rs1  = arch_reg_t'($urandom_range(0, 7));
        rs2  = arch_reg_t'($urandom_range(0, 7));
        if (kind == 0) begin
            opc = 7'($urandom);
            while ((opc == OPCODE_OP) || (opc == OPCODE_OP_IMM) || (opc == OPCODE_LUI)) begin
                opc = 7'($urandom);
            end
            return {25'($urandom), opc};
        end
        if (kind < 3) return enc_u(20'($urandom), rd);
        if (kind < 9) begin
            return enc_r(($urandom_range(0, 3) == 0) ? FUNCT7_ALT : FUNCT7_BASE, rs2, rs1, f3, rd);
        end
        if ((f3 == FUNCT3_SLL) || (f3 == FUNCT3_SR)) begin
            imm[11:5] = ($urandom_range(0, 1) == 0) ? FUNCT7_ALT : FUNCT7_BASE;
        end
        return enc_i(imm, rs1, f3, rd);
    endfunction

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("ERROR: timeout after %0d cycles", cycles);
            abort_run();
        end
    end

    // outputs are settled by the falling edge
    initial begin
        forever begin
            @(negedge clk);
            // a broadcast in the same cycle as an illegal pulse is the older one
            if (cdb_valid_o) begin
                compare_next(1'b0);
            end
            if (illegal_o) begin
                compare_next(1'b1);
            end
        end
    end

    initial begin
        void'($urandom(77));
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        for (int r = 0; r < NUM_ARCH_REGS; r++) model_regs[r] = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n_i = 1'b1;

        repeat (5) begin
            @(negedge clk);
            if (cdb_valid_o || illegal_o) begin
                $display("ERROR: after_reset output active with no instruction driven");
                abort_run();
            end
        end

        // registers still at reset value, then known setup values
        issue("init_regs", enc_r(FUNCT7_BASE, 5'd9, 5'd8, FUNCT3_ADD, 5'd21));
        issue("init_regs", enc_i(12'hFFB, 5'd0, FUNCT3_ADD, 5'd1));
        issue("init_regs", enc_u(20'h80000, 5'd2));
        issue("init_regs", enc_i(12'h007, 5'd0, FUNCT3_ADD, 5'd3));
        for (int f = 0; f < 8; f++) begin
            issue("init_regs", enc_r(FUNCT7_BASE, 5'd3, 5'd1, 3'(f), 5'd16));
            issue("init_regs", enc_r(FUNCT7_BASE, 5'd3, 5'd2, 3'(f), 5'd17));
            issue("init_regs", enc_i(((f == 1) || (f == 5)) ? 12'h003 : 12'hFF0,
                                     5'd1, 3'(f), 5'd18));
        end
        issue("init_regs", enc_r(FUNCT7_ALT, 5'd3, 5'd1, FUNCT3_ADD, 5'd19));
        issue("init_regs", enc_r(FUNCT7_ALT, 5'd3, 5'd2, FUNCT3_SR, 5'd19));
        issue("init_regs", enc_i({FUNCT7_ALT, 5'd4}, 5'd2, FUNCT3_SR, 5'd20));
        issue("init_regs", enc_i({FUNCT7_ALT, 5'd3}, 5'd1, FUNCT3_SR, 5'd20));

        issue("dependencies", enc_i(12'h001, 5'd0, FUNCT3_ADD, 5'd8));
        issue("dependencies", enc_i(12'h002, 5'd0, FUNCT3_ADD, 5'd9));
        for (int i = 0; i < 8; i++) begin
            issue("dependencies", enc_r(FUNCT7_BASE, 5'd9, 5'd8, FUNCT3_ADD, 5'd8));
            issue("dependencies", enc_r(FUNCT7_BASE, 5'd8, 5'd9, FUNCT3_XOR, 5'd9));
        end
        issue("dependencies", enc_i(12'h003, 5'd8, FUNCT3_SLL, 5'd10));
        issue("dependencies", enc_r(FUNCT7_ALT, 5'd10, 5'd8, FUNCT3_ADD, 5'd10));

        issue("x0", enc_i(12'h07B, 5'd0, FUNCT3_ADD, 5'd0));
        issue("x0", enc_r(FUNCT7_BASE, 5'd0, 5'd0, FUNCT3_ADD, 5'd11));
        idle(3);
        issue("x0", enc_i(12'h005, 5'd0, FUNCT3_OR, 5'd11));

        issue("illegal", 32'h0000_2083);
        issue("illegal", 32'h0000_0000);
        issue("illegal", enc_i(12'h001, 5'd12, FUNCT3_ADD, 5'd12));
        issue("illegal", enc_i({FUNCT7_ALT, 5'd1}, 5'd12, FUNCT3_SLL, 5'd12));
        issue("illegal", enc_r(FUNCT7_ALT, 5'd12, 5'd12, FUNCT3_XOR, 5'd13));
        issue("illegal", enc_r(FUNCT7_BASE, 5'd12, 5'd12, FUNCT3_ADD, 5'd13));

        for (int i = 0; i < RAND_COUNT; i++) begin
            issue("random", random_instr());
            if ($urandom_range(0, 7) == 0) idle(int'($urandom_range(1, MAX_GAP)));
        end

        idle(1);
        repeat (4) @(posedge clk);
        if (ill_q.size() != 0) begin
            $display("ERROR: %0d results never arrived", ill_q.size());
            abort_run();
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule : alu_core_tb

// File: verilog.f
hw/alu_core_pkg.sv
hw/alu_decode.sv
hw/alu_execute.sv
hw/alu_result.sv
hw/alu_core.sv
verif/alu_core_tb.sv
